/* rtl/fe_ctrl_macros.svh */
//----------------------------------------------------------
// Widths, queue depth, command addresses and hold-off length
// for the radio front-end control glue. Include where needed.
//----------------------------------------------------------
`ifndef FE_CTRL_MACROS_SVH
`define FE_CTRL_MACROS_SVH

// Command port widths
`define CMD_ADDR_W       2
`define CMD_DATA_W       8

// Command queue entries
`define CMD_FIFO_DEPTH   4

// Cycles of bus_clk before the board is released
`define HOLDOFF_CYCLES   64

// Command addresses, one per control word
`define ADDR_ATR1        2'd0   // Front end 1 ATR pins
`define ADDR_ATR2        2'd1   // Front end 2 ATR pins
`define ADDR_MISC        2'd2   // Band select and ref select
`define ADDR_RADIO_CTRL  2'd3   // Codec reset and MIMO

`endif

/* rtl/fe_ctrl_pkg.sv */
//----------------------------------------------------------
// Command and control word types shared by the queue and the
// register bank. The address picks the control word view.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

package fe_ctrl_pkg;

   // ATR view, also the register type per front end
   typedef struct packed {
      logic tx_enable;     // PA enable
      logic sfdx_rx;       // Full duplex switch, rx side
      logic sfdx_tx;       // Full duplex switch, tx side
      logic srx_rx;        // Rx switch, rx port
      logic srx_tx;        // Rx switch, tx/rx port
      logic led_rx;
      logic led_txrx_rx;
      logic led_txrx_tx;
   } atr_pins_t;

   // Band and reference select view
   typedef struct packed {
      logic [1:0] rsvd;    // Unused
      logic       tx_bandsel_a;
      logic       tx_bandsel_b;
      logic       rx_bandsel_a;
      logic       rx_bandsel_b;
      logic       rx_bandsel_c;
      logic       ref_sel;
   } misc_word_t;

   // Codec control view
   typedef struct packed {
      logic [5:0] rsvd;    // Unused
      logic       codec_arst;
      logic       mimo;
   } radio_word_t;

   // One control word, three decodes
   typedef union packed {
      atr_pins_t   atr;
      misc_word_t  misc;
      radio_word_t radio;
   } ctrl_word_u;

   // One queued command
   typedef struct packed {
      logic [`CMD_ADDR_W-1:0] addr;
      ctrl_word_u             data;
   } cmd_t;

endpackage

/* rtl/cmd_if.sv */
//----------------------------------------------------------
// Valid/ready command channel between the req/ack slave, the
// queue and the register bank. Transfer on valid && ready.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

interface cmd_if;

   logic                   valid;  // Held until accepted
   logic                   ready;
   logic [`CMD_ADDR_W-1:0] addr;   // Target register
   logic [`CMD_DATA_W-1:0] data;   // Control word

   // Producer side
   modport source (
      output valid,
      output addr,
      output data,
      input  ready
   );

   // Consumer side
   modport sink (
      input  valid,
      input  addr,
      input  data,
      output ready
   );

endinterface

/* rtl/clock_holdoff.sv */
//----------------------------------------------------------
// Holds the board off after reset or PLL lock loss until
// HOLDOFF_CYCLES of clean lock have passed on bus_clk.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

module clock_holdoff (
   input  logic bus_clk,
   input  logic reset_global,
   input  logic pll_locked,
   output logic clocks_ready
);

   localparam int CNT_W = $clog2(`HOLDOFF_CYCLES);

   logic [CNT_W-1:0] holdoff_count;
   logic             holdoff_clr;

   // Either event restarts the hold-off at once
   assign holdoff_clr = reset_global | ~pll_locked;

   //----------------------------------------------------------
   // Hold-off counter
   //----------------------------------------------------------
   always_ff @(posedge bus_clk or posedge holdoff_clr) begin
      if (holdoff_clr) begin
         holdoff_count <= '0;
         clocks_ready  <= 1'b0;
      end
      else if (!clocks_ready) begin
         holdoff_count <= holdoff_count + 1'b1;
         // Last count edge releases the board
         clocks_ready  <= (holdoff_count == CNT_W'(`HOLDOFF_CYCLES - 1));
      end
   end

endmodule

/* rtl/cmd_req_slave.sv */
//----------------------------------------------------------
// Four-phase req/ack slave. Captures one command per req
// pulse and acks only once the queue has taken it.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

module cmd_req_slave (
   input  logic                   bus_clk,
   input  logic                   reset_global,
   input  logic                   cmd_req,
   input  logic [`CMD_ADDR_W-1:0] cmd_addr,
   input  logic [`CMD_DATA_W-1:0] cmd_data,
   output logic                   cmd_ack,
   cmd_if.source                  push
);

   typedef enum logic [1:0] {
      S_IDLE,        // Waiting for req
      S_PUSH,        // Offering command to queue
      S_WAIT_LOW     // Ack high, waiting for req to drop
   } state_t;

   state_t                 state;
   logic [`CMD_ADDR_W-1:0] addr_r;
   logic [`CMD_DATA_W-1:0] data_r;

   //----------------------------------------------------------
   // Handshake FSM
   //----------------------------------------------------------
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         state <= S_IDLE;
      end
      else begin
         case (state)
            S_IDLE:
               if (cmd_req)
                  state <= S_PUSH;
            S_PUSH:
               if (push.ready)          // Queue took it
                  state <= S_WAIT_LOW;
            S_WAIT_LOW:
               if (!cmd_req)
                  state <= S_IDLE;
            default:
               state <= S_IDLE;
         endcase
      end
   end

   // Command capture, once per req pulse
   always_ff @(posedge bus_clk) begin
      if (state == S_IDLE && cmd_req) begin
         addr_r <= cmd_addr;
         data_r <= cmd_data;
      end
   end

   assign push.valid = (state == S_PUSH);
   assign push.addr  = addr_r;
   assign push.data  = data_r;
   assign cmd_ack    = (state == S_WAIT_LOW);  // Straight from state flops

endmodule

/* rtl/cmd_fifo.sv */
//----------------------------------------------------------
// Circular command queue with occupancy count. Push and pop
// may happen together; ready drops while full.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

module cmd_fifo import fe_ctrl_pkg::*; #(
   parameter int DEPTH = `CMD_FIFO_DEPTH
) (
   input  logic  bus_clk,
   input  logic  reset_global,
   cmd_if.sink   push,
   cmd_if.source pop
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   cmd_t             mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // Pointer advance with wrap for any depth
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push.ready = (count != CNT_W'(DEPTH));   // Back-pressure when full
   assign pop.valid  = (count != '0);
   assign do_push    = push.valid & push.ready;
   assign do_pop     = pop.valid & pop.ready;

   //----------------------------------------------------------
   // Pointers and occupancy
   //----------------------------------------------------------
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (do_push)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)
            rd_ptr <= next_ptr(rd_ptr);
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   // Storage
   always_ff @(posedge bus_clk) begin
      if (do_push)
         mem[wr_ptr] <= {push.addr, push.data};
   end

   // Head entry, visible the cycle after its push
   assign pop.addr = mem[rd_ptr].addr;
   assign pop.data = mem[rd_ptr].data;

endmodule

/* rtl/fe_ctrl_regs.sv */
//----------------------------------------------------------
// Control register bank. Pops commands once clocks are ready
// and decodes each word into front-end and codec pins.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

module fe_ctrl_regs import fe_ctrl_pkg::*; (
   input  logic      bus_clk,
   input  logic      reset_global,
   input  logic      clocks_ready,
   cmd_if.sink       pop,
   output atr_pins_t fe1_atr,
   output atr_pins_t fe2_atr,
   output logic [5:0] misc_pins,
   output logic      codec_reset,
   output logic      mimo
);

   ctrl_word_u word;        // Queue head, seen through its views
   logic       pop_fire;
   logic       codec_arst;  // Software codec reset

   // Drain only while the board is released
   assign pop.ready = clocks_ready;
   assign pop_fire  = pop.valid & clocks_ready;
   assign word      = pop.data;

   //----------------------------------------------------------
   // Registers, zero while clocks are not ready
   //----------------------------------------------------------
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         fe1_atr    <= '0;
         fe2_atr    <= '0;
         misc_pins  <= '0;
         codec_arst <= 1'b0;
         mimo       <= 1'b0;
      end
      else if (!clocks_ready) begin
         fe1_atr    <= '0;      // Back to safe state
         fe2_atr    <= '0;
         misc_pins  <= '0;
         codec_arst <= 1'b0;
         mimo       <= 1'b0;
      end
      else if (pop_fire) begin
         case (pop.addr)
            `ADDR_ATR1:
               fe1_atr <= word.atr;
            `ADDR_ATR2:
               fe2_atr <= word.atr;
            `ADDR_MISC:
               misc_pins <= {word.misc.tx_bandsel_a,
                             word.misc.tx_bandsel_b,
                             word.misc.rx_bandsel_a,
                             word.misc.rx_bandsel_b,
                             word.misc.rx_bandsel_c,
                             word.misc.ref_sel};
            `ADDR_RADIO_CTRL: begin
               codec_arst <= word.radio.codec_arst;
               mimo       <= word.radio.mimo;
            end
            default: ;
         endcase
      end
   end

   // Codec held in reset until clocks are good
   assign codec_reset = ~clocks_ready | codec_arst;

endmodule

/* rtl/radio_fe_ctrl.sv */
//----------------------------------------------------------
// Top level of the front-end control glue. Ties hold-off,
// command slave, queue and register bank to the board pins.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

module radio_fe_ctrl import fe_ctrl_pkg::*; (
   input  logic                   bus_clk,
   input  logic                   reset_global,
   input  logic                   pll_locked,
   //----------------------------------------------------------
   // Command port
   //----------------------------------------------------------
   input  logic                   cmd_req,
   input  logic [`CMD_ADDR_W-1:0] cmd_addr,
   input  logic [`CMD_DATA_W-1:0] cmd_data,
   output logic                   cmd_ack,
   output logic                   clocks_ready,
   //----------------------------------------------------------
   // Front end 1 and 2 ATR pins
   //----------------------------------------------------------
   output logic tx_enable1, sfdx1_rx, sfdx1_tx, srx1_rx, srx1_tx,
   output logic led_rx1, led_txrx1_rx, led_txrx1_tx,
   output logic tx_enable2, sfdx2_rx, sfdx2_tx, srx2_rx, srx2_tx,
   output logic led_rx2, led_txrx2_rx, led_txrx2_tx,
   //----------------------------------------------------------
   // Band select, reference and codec controls
   //----------------------------------------------------------
   output logic tx_bandsel_a, tx_bandsel_b,
   output logic rx_bandsel_a, rx_bandsel_b, rx_bandsel_c,
   output logic ref_sel,
   output logic codec_reset,
   output logic mimo
);

   cmd_if push_if ();          // Slave to queue
   cmd_if pop_if ();           // Queue to register bank

   atr_pins_t  fe1_atr;
   atr_pins_t  fe2_atr;
   logic [5:0] misc_pins;

   clock_holdoff clock_holdoff_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .pll_locked   (pll_locked),
      .clocks_ready (clocks_ready)
   );

   cmd_req_slave cmd_req_slave_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .cmd_req      (cmd_req),
      .cmd_addr     (cmd_addr),
      .cmd_data     (cmd_data),
      .cmd_ack      (cmd_ack),
      .push         (push_if.source)
   );

   cmd_fifo #(.DEPTH(`CMD_FIFO_DEPTH)) cmd_fifo_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .push         (push_if.sink),
      .pop          (pop_if.source)
   );

   fe_ctrl_regs fe_ctrl_regs_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .clocks_ready (clocks_ready),
      .pop          (pop_if.sink),
      .fe1_atr      (fe1_atr),
      .fe2_atr      (fe2_atr),
      .misc_pins    (misc_pins),
      .codec_reset  (codec_reset),
      .mimo         (mimo)
   );

   // Register fields out to pins, same order as the ATR word
   assign {tx_enable1, sfdx1_rx, sfdx1_tx, srx1_rx, srx1_tx,
           led_rx1, led_txrx1_rx, led_txrx1_tx} = fe1_atr;
   assign {tx_enable2, sfdx2_rx, sfdx2_tx, srx2_rx, srx2_tx,
           led_rx2, led_txrx2_rx, led_txrx2_tx} = fe2_atr;
   assign {tx_bandsel_a, tx_bandsel_b, rx_bandsel_a,
           rx_bandsel_b, rx_bandsel_c, ref_sel} = misc_pins;

endmodule

/* tb/radio_fe_ctrl_sva.sv */
//----------------------------------------------------------
// Concurrent checks on the req/ack handshake, the command
// queue and codec reset. Bound into the top level below.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

module radio_fe_ctrl_sva (
   input logic                                     bus_clk,
   input logic                                     reset_global,
   input logic                                     cmd_req,
   input logic                                     cmd_ack,
   input logic                                     clocks_ready,
   input logic                                     codec_reset,
   input logic [$clog2(`CMD_FIFO_DEPTH + 1)-1:0]   fifo_count
);

   int unsigned assert_fails = 0;   // Read back by the testbench

   // Ack only answers a request seen on the edge that set it
   ack_needs_req: assert property (@(posedge bus_clk) disable iff (reset_global)
      $rose(cmd_ack) |-> $past(cmd_req))
      else begin
         $error("cmd_ack rose without cmd_req");
         assert_fails++;
      end

   // Ack held until req drops
   ack_holds: assert property (@(posedge bus_clk) disable iff (reset_global)
      (cmd_ack && cmd_req) |=> cmd_ack)
      else begin
         $error("cmd_ack dropped while cmd_req still high");
         assert_fails++;
      end

   //----------------------------------------------------------
   // Queue and codec
   //----------------------------------------------------------
   // A push onto a full queue would carry the count past depth
   no_push_full: assert property (@(posedge bus_clk) disable iff (reset_global)
      fifo_count <= `CMD_FIFO_DEPTH)
      else begin
         $error("command queue pushed while full");
         assert_fails++;
      end

   // Codec held through the hold-off, released with codec_arst cleared
   codec_held: assert property (@(posedge bus_clk)
      !clocks_ready |=> (codec_reset != clocks_ready))
      else begin
         $error("codec_reset wrong across the hold-off");
         assert_fails++;
      end

endmodule

bind radio_fe_ctrl radio_fe_ctrl_sva radio_fe_ctrl_sva_i (
   .bus_clk      (bus_clk),
   .reset_global (reset_global),
   .cmd_req      (cmd_req),
   .cmd_ack      (cmd_ack),
   .clocks_ready (clocks_ready),
   .codec_reset  (codec_reset),
   .fifo_count   (cmd_fifo_i.count)
);

/* tb/tb_radio_fe_ctrl.sv */
//----------------------------------------------------------
// Table-driven testbench for the front-end control top level.
// Writes commands over the req/ack port and checks the pins.
//----------------------------------------------------------
`include "fe_ctrl_macros.svh"

module tb_radio_fe_ctrl;

   localparam int NUM_ENTRIES   = 13;
   localparam int ACK_TIMEOUT   = 200;   // Covers a full hold-off
   localparam int PIN_TIMEOUT   = 20;
   localparam int READY_TIMEOUT = 200;
   localparam int DRAIN_TIMEOUT = 40;
   localparam logic [23:0] PINS_RESET = 24'h00_0002;  // Only codec_reset high

   // {addr, data, pins after the write}
   // Pins = {fe1 atr, fe2 atr, misc 6 bits, codec_reset, mimo}
   localparam logic [33:0] CMD_TABLE [NUM_ENTRIES] = '{
      {`ADDR_ATR1,       8'hA5, 24'hA5_00_00},  // Queued in hold-off
      {`ADDR_ATR2,       8'h3C, 24'hA5_3C_00},
      {`ADDR_MISC,       8'hEA, 24'hA5_3C_A8},  // Top two bits unused
      {`ADDR_RADIO_CTRL, 8'h01, 24'hA5_3C_A9},  // mimo only
      {`ADDR_ATR1,       8'h5A, 24'h5A_3C_A9},  // Stalls on full queue
      {`ADDR_ATR2,       8'hFF, 24'h5A_FF_A9},  // ATR decode
      {`ADDR_ATR1,       8'h81, 24'h81_FF_A9},  // fe2 untouched
      {`ADDR_ATR2,       8'h00, 24'h81_00_A9},
      {`ADDR_MISC,       8'h15, 24'h81_00_55},  // Misc and radio decode
      {`ADDR_RADIO_CTRL, 8'h02, 24'h81_00_56},  // codec_arst only
      {`ADDR_RADIO_CTRL, 8'hFC, 24'h81_00_54},  // Upper bits ignored
      {`ADDR_ATR1,       8'h42, 24'h42_00_00},  // After lock returns
      {`ADDR_RADIO_CTRL, 8'h03, 24'h42_00_03}
   };

   logic                   bus_clk;
   logic                   reset_global;
   logic                   pll_locked;
   logic                   cmd_req;
   logic [`CMD_ADDR_W-1:0] cmd_addr;
   logic [`CMD_DATA_W-1:0] cmd_data;
   logic                   cmd_ack;
   logic                   clocks_ready;
   logic tx_enable1, sfdx1_rx, sfdx1_tx, srx1_rx, srx1_tx;
   logic led_rx1, led_txrx1_rx, led_txrx1_tx;
   logic tx_enable2, sfdx2_rx, sfdx2_tx, srx2_rx, srx2_tx;
   logic led_rx2, led_txrx2_rx, led_txrx2_tx;
   logic tx_bandsel_a, tx_bandsel_b, rx_bandsel_a, rx_bandsel_b, rx_bandsel_c;
   logic ref_sel, codec_reset, mimo;
   logic [23:0]            pins;     // All decoded pins in table order
   int                     errors;
   int                     checks;

   radio_fe_ctrl radio_fe_ctrl_i (.*);

   assign pins = {tx_enable1, sfdx1_rx, sfdx1_tx, srx1_rx, srx1_tx,
                  led_rx1, led_txrx1_rx, led_txrx1_tx,
                  tx_enable2, sfdx2_rx, sfdx2_tx, srx2_rx, srx2_tx,
                  led_rx2, led_txrx2_rx, led_txrx2_tx,
                  tx_bandsel_a, tx_bandsel_b, rx_bandsel_a,
                  rx_bandsel_b, rx_bandsel_c, ref_sel, codec_reset, mimo};

   always #5 bus_clk = ~bus_clk;

   //----------------------------------------------------------
   // Helpers
   //----------------------------------------------------------
   task automatic tick();   // Drive and sample just after the edge
      @(posedge bus_clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   // Four-phase write, returns clocks_ready as seen with the ack
   task automatic write_cmd(input logic [1:0] addr, input logic [7:0] data,
                            output logic ready_at_ack);
      int n;
      cmd_addr = addr;
      cmd_data = data;
      cmd_req  = 1'b1;
      n = 0;
      while (!cmd_ack && n < ACK_TIMEOUT) begin
         tick();
         n++;
      end
      if (!cmd_ack) begin
         errors++;
         $display("t=%0t no cmd_ack for write to address %0d", $time, addr);
      end
      ready_at_ack = clocks_ready;
      cmd_req = 1'b0;              // Phase 3
      n = 0;
      while (cmd_ack && n < ACK_TIMEOUT) begin
         tick();
         n++;
      end
      if (cmd_ack) begin
         errors++;
         $display("t=%0t cmd_ack stayed high after cmd_req dropped", $time);
      end
   endtask

   task automatic wait_pins(input logic [23:0] exp);
      int n;
      n = 0;
      while (pins !== exp && n < PIN_TIMEOUT) begin
         tick();
         n++;
      end
      check_value("pins", pins, exp);
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!clocks_ready && n < READY_TIMEOUT) begin
         tick();
         n++;
      end
      if (!clocks_ready) begin
         errors++;
         $display("t=%0t clocks_ready never rose", $time);
      end
   endtask

   // Queued words must land one by one in table order
   task automatic drain_in_order(input int first, input int last);
      int          k;
      int          n;
      logic [23:0] prev;
      k    = first;
      n    = 0;
      prev = 24'h0;                // Released, nothing popped yet
      while (k <= last && n < DRAIN_TIMEOUT) begin
         tick();
         n++;
         if (pins === CMD_TABLE[k][23:0]) begin
            prev = pins;
            k++;
         end
         else if (pins !== prev) begin
            errors++;
            $display("t=%0t pins changed out of table order at entry %0d", $time, k);
            k = last + 2;          // Stop here, one report is enough
         end
      end
      if (k <= last) begin
         errors++;
         $display("t=%0t queued writes did not all take effect", $time);
      end
   endtask

   task automatic run_entries(input int first, input int last);
      logic rdy;
      for (int i = first; i <= last; i++) begin
         write_cmd(CMD_TABLE[i][33:32], CMD_TABLE[i][31:24], rdy);
         wait_pins(CMD_TABLE[i][23:0]);
      end
   endtask

   task automatic report_test(input int num, input string name, input int err_before);
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
   endtask

   //----------------------------------------------------------
   // Main sequence
   //----------------------------------------------------------
   initial begin
      int   err_start;
      logic rdy;
      errors       = 0;
      checks       = 0;
      bus_clk      = 1'b0;
      reset_global = 1'b1;
      pll_locked   = 1'b1;
      cmd_req      = 1'b0;
      cmd_addr     = '0;
      cmd_data     = '0;

      err_start = errors;            // Reset state
      repeat (3) tick();
      check_value("cmd_ack", cmd_ack, 0);
      check_value("clocks_ready", clocks_ready, 0);
      check_value("pins", pins, PINS_RESET);
      repeat (2) tick();
      reset_global = 1'b0;
      tick();
      check_value("cmd_ack", cmd_ack, 0);
      check_value("clocks_ready", clocks_ready, 0);
      check_value("pins", pins, PINS_RESET);
      report_test(1, "reset state", err_start);

      err_start = errors;            // Fill the queue in hold-off
      for (int i = 0; i < 4; i++) begin
         write_cmd(CMD_TABLE[i][33:32], CMD_TABLE[i][31:24], rdy);
         check_value("clocks_ready at cmd_ack", rdy, 0);
         check_value("pins", pins, PINS_RESET);
      end
      fork
         write_cmd(CMD_TABLE[4][33:32], CMD_TABLE[4][31:24], rdy);
         begin
            wait_ready();
            drain_in_order(0, 4);
         end
      join
      report_test(2, "queue during hold-off", err_start);
      err_start = errors;
      check_value("clocks_ready at stalled cmd_ack", rdy, 1);
      report_test(3, "back-pressure", err_start);

      err_start = errors;
      run_entries(5, 7);
      report_test(4, "ATR decode", err_start);
      err_start = errors;
      run_entries(8, 10);
      report_test(5, "misc and radio decode", err_start);

      err_start = errors;            // Lock lost, then regained
      pll_locked = 1'b0;
      #1;
      check_value("clocks_ready", clocks_ready, 0);
      check_value("codec_reset", codec_reset, 1);
      wait_pins(PINS_RESET);
      pll_locked = 1'b1;
      wait_ready();
      check_value("pins", pins, 24'h0);
      run_entries(11, 12);
      report_test(6, "loss of lock", err_start);

      if (radio_fe_ctrl_i.radio_fe_ctrl_sva_i.assert_fails != 0) begin
         $display("%0d assertion failures during the run",
                  radio_fe_ctrl_i.radio_fe_ctrl_sva_i.assert_fails);
         errors += radio_fe_ctrl_i.radio_fe_ctrl_sva_i.assert_fails;
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end
      else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
+incdir+rtl
rtl/fe_ctrl_pkg.sv
rtl/cmd_if.sv
rtl/clock_holdoff.sv
rtl/cmd_req_slave.sv
rtl/cmd_fifo.sv
rtl/fe_ctrl_regs.sv
rtl/radio_fe_ctrl.sv
tb/radio_fe_ctrl_sva.sv
tb/tb_radio_fe_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
set -o pipefail

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f list.f --top-module tb_radio_fe_ctrl -Mdir obj_dir -o tb_sim \
   && ./obj_dir/tb_sim +verilator+error+limit+1000 2>&1 | tee sim.log \
   || echo "build or simulation stopped early" | tee -a sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "No pass result in log"; exit 1; }
echo "Simulation passed"
exit 0
